// ==== filelist.f ====
+incdir+verilog
verilog/adc_link_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/cmd_sequencer.sv
verilog/adc_spi_reader.sv
verilog/sample_fifo.sv
verilog/sample_reporter.sv
verilog/adc_link_top.sv
dv/adc_spi_model.sv
dv/tb_adc_link.sv

// ==== Makefile ====
# Verilator flow for the ADC readout link
VERILATOR ?= verilator
TOP       ?= tb_adc_link
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass text"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "TEST PASSED" || (echo "TEST FAILED"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_adc_link.sv ====
`timescale 1ns/10ps
`include "adc_link_defs.svh"

module tb_adc_link;

    localparam int CLKS_PER_BIT = `ADC_LINK_CLKS_PER_BIT;
    localparam int NUM_VALUES   = 64;
    localparam int RUN_TIMEOUT  = 400 * CLKS_PER_BIT;
    localparam int QUIET_CLKS   = 20 * CLKS_PER_BIT;

    typedef adc_link_pkg::byte_t byte_q_t [$];

    logic                  clk;
    logic                  rst_n;
    logic                  rx;
    logic                  sdo;
    logic                  tx;
    logic                  cs;
    logic                  sclk;
    int                    frames;
    adc_link_pkg::sample_t adc_values [NUM_VALUES];
    byte_q_t               sent_bytes;
    byte_q_t               seen_bytes;
    int                    bytes_checked;
    int                    echoes_checked;
    int                    reports_checked;
    logic                  mid_report;

    adc_link_top adc_link_top_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .sdo   (sdo),
        .tx    (tx),
        .cs    (cs),
        .sclk  (sclk)
    );

    adc_spi_model #(.NUM_VALUES(NUM_VALUES)) adc_spi_model_inst (
        .cs     (cs),
        .sclk   (sclk),
        .values (adc_values),
        .sdo    (sdo),
        .frames (frames)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s at %0t", reason, $time);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // Host view of the protocol with an echo per arm and a report per read
    function automatic byte_q_t expected_bytes(input byte_q_t sent);
        byte_q_t exp;
        logic    armed;
        int      n;
        armed = 1'b0;
        n = 0;
        foreach (sent[i]) begin
            if (sent[i] == `ADC_LINK_CMD_ARM) begin
                exp.push_back(`ADC_LINK_CMD_ARM);
                armed = 1'b1;
            end else if (armed && sent[i] == `ADC_LINK_CMD_READ) begin
                exp.push_back({4'h0, adc_values[n % NUM_VALUES][11:8]});
                exp.push_back(adc_values[n % NUM_VALUES][7:0]);
                n++;
            end
        end
        return exp;
    endfunction

    // A high byte never equals the arm byte so echoes split out cleanly
    function automatic byte_q_t report_bytes(input byte_q_t stream);
        byte_q_t rpts;
        int      i;
        i = 0;
        while (i < stream.size()) begin
            if (stream[i] == `ADC_LINK_CMD_ARM) begin
                i++;
            end else begin
                rpts.push_back(stream[i]);
                rpts.push_back(stream[i + 1]);
                i += 2;
            end
        end
        return rpts;
    endfunction

    function automatic adc_link_pkg::byte_t random_unknown_byte();
        adc_link_pkg::byte_t b;
        b = adc_link_pkg::byte_t'($urandom);
        while (b == `ADC_LINK_CMD_ARM || b == `ADC_LINK_CMD_READ) begin
            b = adc_link_pkg::byte_t'($urandom);
        end
        return b;
    endfunction

    task automatic hold_clks(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            @(negedge clk);
        end
    endtask

    // 8N1 frame on rx with the LSB first
    task automatic send_byte(input adc_link_pkg::byte_t b);
        int waited;
        int i;
        for (waited = 0; rst_n !== 1'b1; waited++) begin
            if (waited >= 64) begin
                abort_run("Reset was never released before sending a byte");
            end else begin
                @(negedge clk);
            end
        end
        sent_bytes.push_back(b);
        rx = 1'b0;
        hold_clks(CLKS_PER_BIT);
        for (i = 0; i < 8; i++) begin
            rx = b[i];
            hold_clks(CLKS_PER_BIT);
        end
        rx = 1'b1;
        hold_clks(CLKS_PER_BIT);
    endtask

    task automatic wait_all_checked(input int limit);
        byte_q_t exp;
        int      waited;
        exp = expected_bytes(sent_bytes);
        waited = 0;
        while (bytes_checked < exp.size()) begin
            if (waited >= limit) begin
                abort_run($sformatf("Timed out waiting for %0d bytes on tx, only %0d arrived",
                                    exp.size(), bytes_checked));
            end else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    task automatic expect_quiet(input int cycles);
        int k;
        for (k = 0; k < cycles; k++) begin
            @(negedge clk);
            if (tx !== 1'b1) begin
                abort_run("The tx line left idle when no reply was due");
            end
        end
    endtask

    // UART monitor sampling tx near each bit middle
    initial begin
        adc_link_pkg::byte_t b;
        int                  i;
        b = '0;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && tx === 1'b0) begin
                hold_clks(CLKS_PER_BIT / 2 - 1);
                if (tx !== 1'b0) begin
                    abort_run("A start bit on tx was too short");
                end else begin
                    for (i = 0; i < 8; i++) begin
                        hold_clks(CLKS_PER_BIT);
                        b[i] = tx;
                    end
                    hold_clks(CLKS_PER_BIT);
                    if (tx !== 1'b1) begin
                        abort_run("A stop bit on tx was low");
                    end else begin
                        seen_bytes.push_back(b);
                    end
                end
            end
        end
    end

    // Echoes may only land between whole reports
    always @(negedge clk) begin
        byte_q_t             exp;
        byte_q_t             rpts;
        adc_link_pkg::byte_t b;
        int                  idx;
        while (seen_bytes.size() > 0) begin
            b = seen_bytes.pop_front();
            exp = expected_bytes(sent_bytes);
            rpts = report_bytes(exp);
            idx = 2 * reports_checked + (mid_report ? 1 : 0);
            if (!mid_report && echoes_checked < exp.size() - rpts.size() &&
                (b == `ADC_LINK_CMD_ARM || idx >= rpts.size())) begin
                check_value(32'(b), 32'(`ADC_LINK_CMD_ARM), "echo byte");
                echoes_checked++;
            end else if (idx >= rpts.size()) begin
                abort_run($sformatf("Unexpected byte 0x%02h on tx", b));
            end else begin
                check_value(32'(b), 32'(rpts[idx]),
                            mid_report ? "report low byte" : "report high byte");
                if (mid_report) begin
                    reports_checked++;
                end
                mid_report = !mid_report;
            end
            bytes_checked++;
        end
    end

    initial begin
        byte_q_t exp;
        byte_q_t rpts;
        int      i;
        rst_n           = 1'b0;
        rx              = 1'b1;
        bytes_checked   = 0;
        echoes_checked  = 0;
        reports_checked = 0;
        mid_report      = 1'b0;
        void'($urandom(32'h01e1_a04e));
        for (i = 0; i < NUM_VALUES; i++) begin
            adc_values[i] = adc_link_pkg::sample_t'($urandom);
        end
        hold_clks(16);
        rst_n = 1'b1;
        hold_clks(2);
        check_value(32'(tx), 32'd1, "tx idle after reset");
        check_value(32'(cs), 32'd1, "cs idle after reset");
        check_value(32'(sclk), 32'd1, "sclk idle after reset");

        // Nothing counts before arming
        send_byte(`ADC_LINK_CMD_READ);
        send_byte(random_unknown_byte());
        send_byte(`ADC_LINK_CMD_READ);
        expect_quiet(QUIET_CLKS);
        check_value(32'(frames), 32'd0, "conversions before arming");

        send_byte(`ADC_LINK_CMD_ARM);
        wait_all_checked(RUN_TIMEOUT);
        send_byte(`ADC_LINK_CMD_ARM);
        wait_all_checked(RUN_TIMEOUT);

        send_byte(`ADC_LINK_CMD_READ);
        wait_all_checked(RUN_TIMEOUT);

        // Burst deep enough to fill the FIFO and run out of credits
        for (i = 0; i < 10; i++) begin
            send_byte(`ADC_LINK_CMD_READ);
        end
        wait_all_checked(RUN_TIMEOUT);

        for (i = 0; i < 6; i++) begin
            send_byte(`ADC_LINK_CMD_READ);
        end
        send_byte(`ADC_LINK_CMD_ARM);
        for (i = 0; i < 3; i++) begin
            send_byte(`ADC_LINK_CMD_READ);
        end
        wait_all_checked(RUN_TIMEOUT);

        send_byte(`ADC_LINK_CMD_READ);
        send_byte(random_unknown_byte());
        send_byte(`ADC_LINK_CMD_READ);
        send_byte(8'h00);
        send_byte(`ADC_LINK_CMD_READ);
        send_byte(random_unknown_byte());
        wait_all_checked(RUN_TIMEOUT);
        expect_quiet(QUIET_CLKS);

        exp = expected_bytes(sent_bytes);
        rpts = report_bytes(exp);
        check_value(32'(frames), 32'(rpts.size() / 2), "ADC conversions");
        $display("No errors");
        $finish;
    end

endmodule

// ==== dv/adc_spi_model.sv ====
`timescale 1ns/10ps

module adc_spi_model #(
    parameter int NUM_VALUES = 64
) (
    input  logic                  cs,
    input  logic                  sclk,
    input  adc_link_pkg::sample_t values [NUM_VALUES],
    output logic                  sdo,
    output int                    frames
);

    logic [15:0] frame_word;
    int          bit_idx;

    initial begin
        sdo        = 1'b0;
        frames     = 0;
        frame_word = '0;
        bit_idx    = 15;
    end

    // sclk idles high, so a falling cs always sees sclk high
    always @(negedge cs or negedge sclk) begin
        if (sclk) begin
            // Leading bits are filler, the reader keeps only the last 12
            frame_word = {4'b1010, values[frames % NUM_VALUES]};
            bit_idx    = 15;
            frames     = frames + 1;
        end else if (!cs) begin
            sdo     <= frame_word[bit_idx];
            bit_idx  = bit_idx - 1;
        end
    end

endmodule

// ==== verilog/adc_link_top.sv ====
`timescale 1ns/10ps

module adc_link_top (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    input  logic sdo,
    output logic tx,
    output logic cs,
    output logic sclk
);

    adc_link_pkg::uart_byte_t   rx_byte;
    adc_link_pkg::sample_beat_t push;
    adc_link_pkg::sample_beat_t head;
    logic                       echo_req;
    logic                       conv_req;
    logic                       pop;
    logic                       credit_ret;

    uart_rx uart_rx_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx      (rx),
        .rx_byte (rx_byte)
    );

    cmd_sequencer cmd_sequencer_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_byte  (rx_byte),
        .echo_req (echo_req),
        .conv_req (conv_req)
    );

    // Producer, gated by credits from the buffer
    adc_spi_reader adc_spi_reader_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .conv_req   (conv_req),
        .credit_ret (credit_ret),
        .sdo        (sdo),
        .cs         (cs),
        .sclk       (sclk),
        .push       (push)
    );

    sample_fifo sample_fifo_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .pop        (pop),
        .push       (push),
        .head       (head),
        .credit_ret (credit_ret)
    );

    sample_reporter sample_reporter_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .echo_req (echo_req),
        .head     (head),
        .pop      (pop),
        .tx       (tx)
    );

endmodule

// ==== verilog/sample_reporter.sv ====
`timescale 1ns/10ps
`include "adc_link_defs.svh"

module sample_reporter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       echo_req,
    input  adc_link_pkg::sample_beat_t head,
    output logic                       pop,
    output logic                       tx
);

    adc_link_pkg::rpt_state_t state;
    adc_link_pkg::byte_t      tx_data;
    adc_link_pkg::byte_t      low_q;
    logic                     tx_start;
    logic                     tx_busy;
    logic                     echo_pend;
    logic                     send_echo;
    logic                     send_low;

    // Echo wins, but only between complete reports
    assign send_echo = (state == adc_link_pkg::RPT_IDLE) && !tx_busy && echo_pend;
    assign pop       = (state == adc_link_pkg::RPT_IDLE) && !tx_busy && !echo_pend &&
                       head.valid;
    assign send_low  = (state == adc_link_pkg::RPT_HIGH) && !tx_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= adc_link_pkg::RPT_IDLE;
            echo_pend <= 1'b0;
            tx_start  <= 1'b0;
        end else begin
            echo_pend <= echo_req || (echo_pend && !send_echo);
            tx_start  <= send_echo || pop || send_low;
            case (state)
                adc_link_pkg::RPT_IDLE: begin
                    if (send_echo) begin
                        state <= adc_link_pkg::RPT_ECHO;
                    end else if (pop) begin
                        state <= adc_link_pkg::RPT_HIGH;
                    end
                end
                adc_link_pkg::RPT_HIGH: begin
                    if (send_low) begin
                        state <= adc_link_pkg::RPT_LOW;
                    end
                end
                default: begin
                    // Echo or low byte still on the line
                    if (!tx_busy) begin
                        state <= adc_link_pkg::RPT_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (send_echo) begin
            tx_data <= `ADC_LINK_CMD_ARM;
        end else if (pop) begin
            tx_data <= {4'h0, head.value[11:8]};
            low_q   <= head.value[7:0];
        end else if (send_low) begin
            tx_data <= low_q;
        end
    end

    uart_tx uart_tx_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

// ==== verilog/sample_fifo.sv ====
`timescale 1ns/10ps
`include "adc_link_defs.svh"

module sample_fifo (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pop,
    input  adc_link_pkg::sample_beat_t push,
    output adc_link_pkg::sample_beat_t head,
    output logic                       credit_ret
);

    localparam int unsigned DEPTH = `ADC_LINK_FIFO_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    adc_link_pkg::sample_t mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W:0]        count;
    logic                  do_pop;

    // Credits keep the writer from ever overrunning the buffer
    assign do_pop = pop && (count != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            credit_ret <= do_pop;
            if (push.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push.valid && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !push.valid) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push.valid) begin
            mem[wr_ptr] <= push.value;
        end
    end

    assign head = '{valid: (count != '0), value: mem[rd_ptr]};

endmodule

// ==== verilog/adc_spi_reader.sv ====
`timescale 1ns/10ps
`include "adc_link_defs.svh"

module adc_spi_reader (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       conv_req,
    input  logic                       credit_ret,
    input  logic                       sdo,
    output logic                       cs,
    output logic                       sclk,
    output adc_link_pkg::sample_beat_t push
);

    localparam int unsigned SCLK_HALF = `ADC_LINK_SCLK_HALF;
    localparam logic [15:0] HALF_LAST = 16'(SCLK_HALF - 1);
    localparam adc_link_pkg::credit_t CREDIT_INIT = adc_link_pkg::credit_t'(`ADC_LINK_FIFO_DEPTH);

    adc_link_pkg::spi_state_t state;
    adc_link_pkg::credit_t    credits;
    logic [3:0]               pending;
    logic [15:0]              half_cnt;
    logic [4:0]               edge_cnt;
    logic [15:0]              shift_q;
    logic                     push_valid;
    logic                     start;
    logic                     toggle;
    logic                     done;

    assign start  = (state == adc_link_pkg::SPI_IDLE) && (pending != 4'd0) &&
                    (credits != '0);
    assign toggle = (state == adc_link_pkg::SPI_SHIFT) && (half_cnt == HALF_LAST);
    assign done   = (state == adc_link_pkg::SPI_DONE);

    // Pending reads saturate at 15
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else if (conv_req && !start && pending != 4'd15) begin
            pending <= pending + 4'd1;
        end else if (start && !conv_req) begin
            pending <= pending - 4'd1;
        end
    end

    // One credit used per push, one returned per FIFO release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CREDIT_INIT;
        end else begin
            credits <= credits + adc_link_pkg::credit_t'(credit_ret)
                               - adc_link_pkg::credit_t'(done);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= adc_link_pkg::SPI_IDLE;
            cs         <= 1'b1;
            sclk       <= 1'b1;
            half_cnt   <= '0;
            edge_cnt   <= '0;
            push_valid <= 1'b0;
        end else begin
            push_valid <= 1'b0;
            case (state)
                adc_link_pkg::SPI_IDLE: begin
                    half_cnt <= '0;
                    edge_cnt <= '0;
                    if (start) begin
                        cs    <= 1'b0;
                        state <= adc_link_pkg::SPI_SHIFT;
                    end
                end
                adc_link_pkg::SPI_SHIFT: begin
                    if (toggle) begin
                        half_cnt <= '0;
                        sclk     <= ~sclk;
                        edge_cnt <= edge_cnt + 5'd1;
                        // 32 edges, the last one rising
                        if (edge_cnt == 5'd31) begin
                            state <= adc_link_pkg::SPI_DONE;
                        end
                    end else begin
                        half_cnt <= half_cnt + 16'd1;
                    end
                end
                default: begin
                    push_valid <= 1'b1;
                    cs         <= 1'b1;
                    state      <= adc_link_pkg::SPI_IDLE;
                end
            endcase
        end
    end

    // Capture sdo as sclk rises, MSB first
    always_ff @(posedge clk) begin
        if (toggle && !sclk) begin
            shift_q <= {shift_q[14:0], sdo};
        end
    end

    assign push = '{valid: push_valid, value: shift_q[11:0]};

endmodule

// ==== verilog/cmd_sequencer.sv ====
`timescale 1ns/10ps
`include "adc_link_defs.svh"

module cmd_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  adc_link_pkg::uart_byte_t rx_byte,
    output logic                     echo_req,
    output logic                     conv_req
);

    adc_link_pkg::seq_state_t state;
    logic                     is_arm;
    logic                     is_read;

    assign is_arm  = rx_byte.valid && (rx_byte.data == `ADC_LINK_CMD_ARM);
    assign is_read = rx_byte.valid && (rx_byte.data == `ADC_LINK_CMD_READ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= adc_link_pkg::SEQ_IDLE;
            echo_req <= 1'b0;
            conv_req <= 1'b0;
        end else begin
            echo_req <= 1'b0;
            conv_req <= 1'b0;
            case (state)
                adc_link_pkg::SEQ_IDLE: begin
                    // Everything but the arm byte is dropped here
                    if (is_arm) begin
                        echo_req <= 1'b1;
                        state    <= adc_link_pkg::SEQ_ARMED;
                    end
                end
                default: begin
                    if (is_arm) begin
                        echo_req <= 1'b1;
                    end
                    if (is_read) begin
                        conv_req <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/10ps
`include "adc_link_defs.svh"

module uart_tx (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                tx_start,
    input  adc_link_pkg::byte_t tx_data,
    output logic                tx,
    output logic                tx_busy
);

    localparam int unsigned CLKS_PER_BIT = `ADC_LINK_CLKS_PER_BIT;
    localparam logic [15:0] BIT_LAST = 16'(CLKS_PER_BIT - 1);

    adc_link_pkg::uart_state_t state;
    adc_link_pkg::byte_t       data_q;
    logic [15:0]               cnt;
    logic [2:0]                bit_idx;
    logic                      bit_end;

    assign bit_end = (cnt == BIT_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= adc_link_pkg::UART_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            cnt <= (state == adc_link_pkg::UART_IDLE || bit_end) ? 16'd0 : cnt + 16'd1;
            case (state)
                adc_link_pkg::UART_IDLE: begin
                    bit_idx <= '0;
                    if (tx_start) begin
                        state <= adc_link_pkg::UART_START;
                    end
                end
                adc_link_pkg::UART_START: begin
                    if (bit_end) begin
                        state <= adc_link_pkg::UART_DATA;
                    end
                end
                adc_link_pkg::UART_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= adc_link_pkg::UART_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= adc_link_pkg::UART_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == adc_link_pkg::UART_IDLE && tx_start) begin
            data_q <= tx_data;
        end
    end

    // Start low, data LSB first, stop and idle high
    always_comb begin
        case (state)
            adc_link_pkg::UART_START: tx = 1'b0;
            adc_link_pkg::UART_DATA:  tx = data_q[bit_idx];
            default:                  tx = 1'b1;
        endcase
    end

    assign tx_busy = tx_start || (state != adc_link_pkg::UART_IDLE);

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/10ps
`include "adc_link_defs.svh"

module uart_rx (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rx,
    output adc_link_pkg::uart_byte_t rx_byte
);

    localparam int unsigned CLKS_PER_BIT = `ADC_LINK_CLKS_PER_BIT;
    localparam logic [15:0] BIT_LAST = 16'(CLKS_PER_BIT - 1);
    localparam logic [15:0] HALF_LAST = 16'(CLKS_PER_BIT / 2 - 1);

    adc_link_pkg::uart_state_t state;
    adc_link_pkg::byte_t       shift_q;
    logic [1:0]                rx_sync;
    logic [15:0]               cnt;
    logic [2:0]                bit_idx;
    logic                      byte_valid;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= adc_link_pkg::UART_IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                adc_link_pkg::UART_IDLE: begin
                    cnt <= '0;
                    if (!rx_sync[1]) begin
                        state <= adc_link_pkg::UART_START;
                    end
                end
                adc_link_pkg::UART_START: begin
                    // Recheck the start bit at its middle, then align to mid-bit
                    if (cnt == HALF_LAST) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync[1] ? adc_link_pkg::UART_IDLE
                                              : adc_link_pkg::UART_DATA;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                adc_link_pkg::UART_DATA: begin
                    if (cnt == BIT_LAST) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= adc_link_pkg::UART_STOP;
                        end
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                default: begin
                    // Low stop bit means a framing error, byte dropped
                    if (cnt == BIT_LAST) begin
                        cnt        <= '0;
                        byte_valid <= rx_sync[1];
                        state      <= adc_link_pkg::UART_IDLE;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == adc_link_pkg::UART_DATA && cnt == BIT_LAST) begin
            shift_q <= {rx_sync[1], shift_q[7:1]};
        end
    end

    assign rx_byte = '{valid: byte_valid, data: shift_q};

endmodule

// ==== verilog/adc_link_pkg.sv ====
package adc_link_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [11:0] sample_t;
    typedef logic [3:0] credit_t;

    // Received UART byte with its strobe
    typedef struct packed {
        logic  valid;
        byte_t data;
    } uart_byte_t;

    // One ADC sample moving through the buffer
    typedef struct packed {
        logic    valid;
        sample_t value;
    } sample_beat_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_ARMED
    } seq_state_t;

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,
        SPI_DONE
    } spi_state_t;

    typedef enum logic [1:0] {
        RPT_IDLE,
        RPT_ECHO,
        RPT_HIGH,
        RPT_LOW
    } rpt_state_t;

    // Shared by receiver and transmitter
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

endpackage

// ==== verilog/adc_link_defs.svh ====
`ifndef ADC_LINK_DEFS_SVH
`define ADC_LINK_DEFS_SVH

// UART bit period in clk cycles
`define ADC_LINK_CLKS_PER_BIT 32'd16

// Half period of the ADC serial clock in clk cycles
`define ADC_LINK_SCLK_HALF 32'd2

// Sample buffer entries, also the initial credit count (power of two)
`define ADC_LINK_FIFO_DEPTH 32'd4

// Host command bytes
`define ADC_LINK_CMD_ARM 8'h33
`define ADC_LINK_CMD_READ 8'h9B

`endif
